//--- aemb_config.svh
`ifndef AEMB_CONFIG_SVH
`define AEMB_CONFIG_SVH

// Front end configuration

// First fetch address out of reset
`define AEMB_RESET_VECTOR 32'h0000_0000

// Interrupt handler entry point
// Only the low half is carried in the injected branch
`define AEMB_INT_VECTOR 32'h0000_0010

// Link register for the interrupt return address
`define AEMB_INT_RETREG 5'd14

// General purpose register count
// Register 0 included, always reads zero
`define AEMB_NUM_REGS 32

`endif

//--- aembPkg.sv
`default_nettype none

package aembPkg;

   // Instruction word, also the data path width
   typedef logic [31:0] insnWord_t;

   // Register file index
   typedef logic [4:0] regAddr_t;

   // Immediate half of a type B word
   typedef logic [15:0] imm16_t;

   // Opcodes the instruction buffer looks at
   // Everything else passes through as a plain 6-bit value
   typedef enum logic [5:0] {
      // Unconditional branch, register target
      BR   = 6'o46,
      // Conditional branch, register offset
      BCC  = 6'o47,
      // Upper half prefix for the next immediate
      IMM  = 6'o54,
      // Return from subroutine
      RTD  = 6'o55,
      // Unconditional branch, immediate target
      BRI  = 6'o56,
      // Conditional branch, immediate offset
      BCCI = 6'o57
   } aembOpcode_t;

endpackage

`default_nettype wire

//--- insnFetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "aemb_config.svh"

module insnFetch import aembPkg::*; (
   input  wire             gclk,
   input  wire             grst,
   input  wire             dEn,
   input  wire             branchTaken,
   input  wire insnWord_t  branchTarget,
   // AXI4-Lite read address channel
   output insnWord_t       araddr,
   output logic            arvalid,
   output logic [2:0]      arprot,
   input  wire             arready,
   // AXI4-Lite read data channel
   input  wire insnWord_t  rdata,
   input  wire [1:0]       rresp,
   input  wire             rvalid,
   output logic            rready,
   // Held word towards the buffer
   output insnWord_t       insnData,
   output logic            insnValid
);

   // Next address to request
   insnWord_t pc;
   insnWord_t fetchPc;
   insnWord_t holdData;
   logic      holdValid;
   // Address accepted, data not yet returned
   logic      rdPending;
   // Response in flight belongs to the old path
   logic      discard;
   logic      arHs;
   logic      rHs;
   logic      launch;

   assign arHs = arvalid & arready;
   assign rHs  = rvalid & rready;

   // New request right after a response, or when nothing is in flight
   assign launch = rHs | (~arvalid & ~rdPending);

   // Redirect in the launch cycle goes straight to the target
   assign fetchPc = branchTaken ? branchTarget : pc;

   // Accept data only if the holding slot frees up
   // Stale responses are always drained
   assign rready = rdPending & (discard | ~holdValid | dEn);

   // Unprivileged, secure, instruction access
   assign arprot = 3'b100;

   assign insnData  = holdData;
   assign insnValid = holdValid;

   always_ff @(posedge gclk) begin
      if (grst) begin
         arvalid   <= 1'b0;
         rdPending <= 1'b0;
         discard   <= 1'b0;
         holdValid <= 1'b0;
         pc        <= `AEMB_RESET_VECTOR;
      end else begin
         // Valid stays up until the slave takes the address
         arvalid   <= launch | (arvalid & ~arready);
         rdPending <= arHs | (rdPending & ~rHs);

         // Mark anything outstanding at a redirect as stale
         discard <= (discard | (branchTaken & (arvalid | rdPending))) & ~rHs;

         // One word step per issued read
         if (launch) begin
            pc <= fetchPc + 32'd4;
         end else if (branchTaken) begin
            pc <= branchTarget;
         end

         // Redirect wins over both fill and release
         if (branchTaken) begin
            holdValid <= 1'b0;
         end else if (rHs & ~discard) begin
            holdValid <= 1'b1;
         end else if (dEn) begin
            holdValid <= 1'b0;
         end
      end
   end

   // Address and data registers
   always_ff @(posedge gclk) begin
      if (launch) begin
         araddr <= fetchPc;
      end
      if (rHs) begin
         holdData <= rdata;
      end
   end

   // Address must not move while the slave is still deciding
   assert property (@(posedge gclk) disable iff (grst)
      arvalid && !arready |=> arvalid && $stable(araddr));

   // Slave only answers a read we actually issued
   assert property (@(posedge gclk) disable iff (grst)
      rvalid |-> rdPending && !$isunknown(rresp));

endmodule

`default_nettype wire

//--- insnBuffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "aemb_config.svh"

module insnBuffer import aembPkg::*; (
   input  wire             gclk,
   input  wire             grst,
   input  wire             dEn,
   input  wire             flush,
   input  wire             msrIe,
   input  wire             irq,
   input  wire insnWord_t  insnData,
   // Decoded word
   output logic            decValid,
   output aembOpcode_t     rOpc,
   output regAddr_t        rRd,
   output regAddr_t        rRa,
   output regAddr_t        rRb,
   output imm16_t          rImm,
   output logic [10:0]     rAlt,
   output insnWord_t       sImm,
   // Register addresses of the word about to be latched
   output regAddr_t        regfRa,
   output regAddr_t        regfRb,
   output regAddr_t        regfRd
);

   localparam insnWord_t intVector = `AEMB_INT_VECTOR;

   // BRALI: BRI with link and absolute bits set in the rA field
   localparam insnWord_t intInsn = {BRI, `AEMB_INT_RETREG, 5'h0c, intVector[15:0]};

   // Interrupt synchroniser and edge detect
   logic [1:0] intSync;
   logic       intShot;
   logic       intLatch;
   logic       isImm;
   logic       isRtd;
   logic       isBranch;
   logic       canInject;
   logic       intIssue;
   insnWord_t  nextWord;
   insnWord_t  nextSImm;

   assign intShot = intSync[0] & ~intSync[1];

   // Words that own the following slot
   assign isImm    = (rOpc == IMM);
   assign isRtd    = (rOpc == RTD);
   assign isBranch = rOpc inside {BR, BRI, BCC, BCCI};

   assign canInject = intLatch & ~isImm & ~isRtd & ~isBranch;
   assign intIssue  = dEn & ~flush & canInject;

   // Fetched word, or the interrupt branch in its place
   assign nextWord = canInject ? intInsn : insnData;

   // IMM prefix supplies the upper half
   assign nextSImm = isImm ? {rImm, nextWord[15:0]}
                           : {{16{nextWord[15]}}, nextWord[15:0]};

   assign regfRd = nextWord[25:21];
   assign regfRa = nextWord[20:16];
   assign regfRb = nextWord[15:11];

   // Type A view of the immediate field
   assign rRb  = rImm[15:11];
   assign rAlt = rImm[10:0];

   // Interrupt latch, runs through stalls
   always_ff @(posedge gclk) begin
      if (grst) begin
         intSync  <= 2'b00;
         intLatch <= 1'b0;
      end else begin
         if (msrIe) begin
            intSync <= {intSync[0], irq};
         end
         // Cleared by issue or by masking
         intLatch <= ((intLatch & ~intIssue) | intShot) & msrIe;
      end
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         decValid <= 1'b0;
         rOpc     <= aembOpcode_t'(6'o00);
      end else if (flush) begin
         decValid <= 1'b0;
      end else if (dEn) begin
         decValid <= 1'b1;
         rOpc     <= aembOpcode_t'(nextWord[31:26]);
      end
   end

   // Field registers
   always_ff @(posedge gclk) begin
      if (dEn && !flush) begin
         rRd  <= nextWord[25:21];
         rRa  <= nextWord[20:16];
         rImm <= nextWord[15:0];
         sImm <= nextSImm;
      end
   end

   // Prefix and its operand stay together
   assert property (@(posedge gclk) disable iff (grst)
      dEn && !flush && rOpc == IMM |=> {rOpc, rRd, rRa, rImm} == $past(insnData));

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "aemb_config.svh"

module regFile import aembPkg::*; (
   input  wire             gclk,
   input  wire             grst,
   input  wire             dEn,
   // Read addresses from the buffer
   input  wire regAddr_t   regfRa,
   input  wire regAddr_t   regfRb,
   input  wire regAddr_t   regfRd,
   // Write back port
   input  wire             wbEn,
   input  wire regAddr_t   wbAddr,
   input  wire insnWord_t  wbData,
   // Operands aligned with the decoded word
   output insnWord_t       opA,
   output insnWord_t       opB,
   output insnWord_t       opD
);

   insnWord_t regMem [`AEMB_NUM_REGS];

   // Register 0 hardwired, same edge write forwarded
   function automatic insnWord_t readPort(input regAddr_t addr);
      if (addr == '0) begin
         return '0;
      end
      if (wbEn && wbAddr == addr) begin
         return wbData;
      end
      return regMem[addr];
   endfunction

   // Write port, register 0 never stored
   always_ff @(posedge gclk) begin
      if (wbEn && wbAddr != '0) begin
         regMem[wbAddr] <= wbData;
      end
   end

   // Operand registers move with the buffer
   always_ff @(posedge gclk) begin
      if (grst) begin
         opA <= '0;
         opB <= '0;
         opD <= '0;
      end else if (dEn) begin
         opA <= readPort(regfRa);
         opB <= readPort(regfRb);
         opD <= readPort(regfRd);
      end
   end

endmodule

`default_nettype wire

//--- aembFrontEnd.sv
`timescale 1ns/1ps
`default_nettype none

module aembFrontEnd import aembPkg::*; (
   input  wire             gclk,
   input  wire             grst,
   // AXI4-Lite instruction read
   output insnWord_t       araddr,
   output logic            arvalid,
   output logic [2:0]      arprot,
   input  wire             arready,
   input  wire insnWord_t  rdata,
   input  wire [1:0]       rresp,
   input  wire             rvalid,
   output logic            rready,
   // Machine state and pipeline control
   input  wire             msrIe,
   input  wire             irq,
   input  wire             stall,
   input  wire             branchTaken,
   input  wire insnWord_t  branchTarget,
   // Register write back
   input  wire             wbEn,
   input  wire regAddr_t   wbAddr,
   input  wire insnWord_t  wbData,
   // Decoded word and operands
   output logic            decValid,
   output aembOpcode_t     rOpc,
   output regAddr_t        rRd,
   output regAddr_t        rRa,
   output regAddr_t        rRb,
   output imm16_t          rImm,
   output insnWord_t       sImm,
   output insnWord_t       opA,
   output insnWord_t       opB,
   output insnWord_t       opD
);

   insnWord_t insnData;
   logic      insnValid;
   // Advance enable for fetch, buffer and register file
   logic      dEn;
   regAddr_t  regfRa;
   regAddr_t  regfRb;
   regAddr_t  regfRd;

   // Move only with a word ready and no hold from downstream
   assign dEn = insnValid & ~stall;

   insnFetch uFetch (
      .gclk         (gclk),
      .grst         (grst),
      .dEn          (dEn),
      .branchTaken  (branchTaken),
      .branchTarget (branchTarget),
      .araddr       (araddr),
      .arvalid      (arvalid),
      .arprot       (arprot),
      .arready      (arready),
      .rdata        (rdata),
      .rresp        (rresp),
      .rvalid       (rvalid),
      .rready       (rready),
      .insnData     (insnData),
      .insnValid    (insnValid)
   );

   // Type A extended field not needed outside
   insnBuffer uBuffer (
      .gclk     (gclk),
      .grst     (grst),
      .dEn      (dEn),
      .flush    (branchTaken),
      .msrIe    (msrIe),
      .irq      (irq),
      .insnData (insnData),
      .decValid (decValid),
      .rOpc     (rOpc),
      .rRd      (rRd),
      .rRa      (rRa),
      .rRb      (rRb),
      .rImm     (rImm),
      .rAlt     (),
      .sImm     (sImm),
      .regfRa   (regfRa),
      .regfRb   (regfRb),
      .regfRd   (regfRd)
   );

   regFile uRegFile (
      .gclk   (gclk),
      .grst   (grst),
      .dEn    (dEn),
      .regfRa (regfRa),
      .regfRb (regfRb),
      .regfRd (regfRd),
      .wbEn   (wbEn),
      .wbAddr (wbAddr),
      .wbData (wbData),
      .opA    (opA),
      .opB    (opB),
      .opD    (opD)
   );

endmodule

`default_nettype wire

//--- tbInsnMem.sv
`timescale 1ns/1ps
`default_nettype none

module tbInsnMem import aembPkg::*; #(
   parameter logic [31:0] Seed = 32'h81e4c987
) (
   input  wire             gclk,
   input  wire             grst,
   // AXI4-Lite read address channel
   input  wire insnWord_t  araddr,
   input  wire             arvalid,
   output logic            arready,
   // AXI4-Lite read data channel
   output insnWord_t       rdata,
   output logic [1:0]      rresp,
   output logic            rvalid,
   input  wire             rready
);

   // 1 KiB of instruction words, loaded by the tests
   insnWord_t   mem [256];
   logic [31:0] lfsr;
   logic [7:0]  addrQ;
   // Address taken, response not yet finished
   logic        busy;
   logic [1:0]  delay;

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function logic nextBit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   // Quiet bus before the first clock
   initial begin
      arready = 1'b0;
      rvalid  = 1'b0;
      rresp   = 2'b00;
      rdata   = '0;
   end

   always @(posedge gclk) begin
      if (grst) begin
         lfsr = Seed;
         arready <= 1'b0;
         rvalid  <= 1'b0;
         rresp   <= 2'b00;
         busy    <= 1'b0;
         delay   <= 2'd0;
      end else begin
         // Random ready while idle, dropped after the address handshake
         if (arvalid && arready) begin
            addrQ   <= araddr[9:2];
            busy    <= 1'b1;
            arready <= 1'b0;
            delay   <= {nextBit(), nextBit()};
         end else if (!busy) begin
            arready <= nextBit();
         end
         // Response after 0 to 3 extra cycles
         if (busy && !rvalid) begin
            if (delay == 2'd0) begin
               rvalid <= 1'b1;
               rdata  <= mem[addrQ];
               rresp  <= 2'b00;
            end else begin
               delay <= delay - 2'd1;
            end
         end
         if (rvalid && rready) begin
            rvalid <= 1'b0;
            busy   <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- tbAembFrontEnd.sv
`timescale 1ns/1ps
`default_nettype none

`include "aemb_config.svh"

module tbAembFrontEnd import aembPkg::*; ();

   logic gclk, grst, msrIe, irq, stall, branchTaken, wbEn;
   logic arvalid, arready, rvalid, rready, decValid;
   logic [2:0] arprot;
   logic [1:0] rresp;
   insnWord_t araddr, rdata, branchTarget, wbData, sImm, opA, opB, opD;
   regAddr_t wbAddr, rRd, rRa, rRb;
   aembOpcode_t rOpc;
   imm16_t rImm;

   // BRI, link reg, link and absolute bits, vector as immediate
   localparam insnWord_t braliWord =
      {BRI, `AEMB_INT_RETREG, 5'h0c, 16'(`AEMB_INT_VECTOR)};

   int errors = 0;
   int timeouts = 0;
   // Decoded words with operands, packed opD opB opA sImm rRb word
   logic [191:0] decQ [$];
   bit advNext = 1'b0;
   insnWord_t curWord, curSImm, curA, curB, curD;
   regAddr_t curRb;

   aembFrontEnd DUT (.*);

   tbInsnMem #(.Seed(32'h81e4c987)) uMem (
      .gclk(gclk), .grst(grst), .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
   );

   initial begin
      gclk = 1'b0;
      forever #4 gclk = ~gclk;
   end

   task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic finishRun();
      $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   endtask

   // Advance seen at one falling edge, new outputs at the next
   always @(negedge gclk) begin
      // Instruction fetch must flag an instruction access
      if (arvalid) begin
         checkEq("arprot", 32'(arprot[2]), 32'd1);
      end
      if (advNext) begin
         checkEq("decValid", 32'(decValid), 32'd1);
         decQ.push_back({opD, opB, opA, sImm, 27'd0, rRb, rOpc, rRd, rRa, rImm});
      end
      advNext = DUT.dEn && !branchTaken && !grst;
   end

   // Address dependent filler, opcode 10 octal is no branch
   function automatic insnWord_t fillWord(input int idx);
      logic [7:0] i;
      i = idx[7:0];
      return {6'o10, 2'b01, i ^ 8'h5a, i, ~i};
   endfunction

   task automatic loadProgram();
      for (int k = 0; k < 256; k++) begin
         uMem.mem[k[7:0]] = fillWord(k);
      end
   endtask

   task automatic applyReset();
      @(posedge gclk);
      grst <= 1'b1;
      repeat (2) @(posedge gclk);
      grst <= 1'b0;
      decQ.delete();
      // Nothing requested or decoded straight out of reset
      @(negedge gclk);
      checkEq("arvalid", 32'(arvalid), 32'd0);
      checkEq("rready", 32'(rready), 32'd0);
      checkEq("decValid", 32'(decValid), 32'd0);
   endtask

   task automatic nextDecoded();
      int t;
      logic [191:0] e;
      t = 0;
      while (decQ.size() == 0 && t < 300) begin
         @(negedge gclk);
         t++;
      end
      if (decQ.size() == 0) begin
         timeouts++;
         $display("Timeout while waiting for a decoded word");
         finishRun();
      end else begin
         e = decQ.pop_front();
         curWord = e[31:0];
         curRb = e[36:32];
         curSImm = e[95:64];
         curA = e[127:96];
         curB = e[159:128];
         curD = e[191:160];
      end
   endtask

   task automatic checkFields(input insnWord_t exp);
      checkEq("rOpc", 32'(curWord[31:26]), 32'(exp[31:26]));
      checkEq("rRd", 32'(curWord[25:21]), 32'(exp[25:21]));
      checkEq("rRa", 32'(curWord[20:16]), 32'(exp[20:16]));
      checkEq("rRb", 32'(curRb), 32'(exp[15:11]));
      checkEq("rImm", 32'(curWord[15:0]), 32'(exp[15:0]));
   endtask

   task automatic writeReg(input int r, input insnWord_t v);
      @(posedge gclk);
      wbEn <= 1'b1;
      wbAddr <= 5'(r);
      wbData <= v;
      @(posedge gclk);
      wbEn <= 1'b0;
   endtask

   task automatic sequentialDecode();
      loadProgram();
      applyReset();
      for (int k = 0; k < 12; k++) begin
         nextDecoded();
         checkFields(uMem.mem[k[7:0]]);
      end
   endtask

   task automatic immediateForms();
      loadProgram();
      uMem.mem[0] = {6'o10, 5'd1, 5'd2, 16'h8001};
      uMem.mem[1] = {IMM, 10'd0, 16'h1234};
      uMem.mem[2] = {6'o10, 5'd3, 5'd4, 16'habcd};
      uMem.mem[3] = {6'o10, 5'd5, 5'd6, 16'h7ffe};
      applyReset();
      nextDecoded();
      checkEq("sImm", curSImm, 32'hffff8001);
      nextDecoded();
      checkFields(uMem.mem[1]);
      // Prefix high half joined with the low half
      nextDecoded();
      checkEq("sImm", curSImm, 32'h1234abcd);
      nextDecoded();
      checkEq("sImm", curSImm, 32'h00007ffe);
   endtask

   task automatic operandReads();
      loadProgram();
      uMem.mem[0] = {6'o10, 5'd3, 5'd1, 5'd2, 11'd0};
      uMem.mem[1] = {6'o10, 5'd0, 5'd0, 5'd1, 11'd0};
      @(posedge gclk);
      stall <= 1'b1;
      applyReset();
      writeReg(1, 32'h11112222);
      writeReg(2, 32'h33334444);
      writeReg(3, 32'h55556666);
      writeReg(0, 32'hdeadbeef);
      @(posedge gclk);
      stall <= 1'b0;
      nextDecoded();
      checkEq("opA", curA, 32'h11112222);
      checkEq("opB", curB, 32'h33334444);
      checkEq("opD", curD, 32'h55556666);
      // Register 0 ignores the write
      nextDecoded();
      checkEq("opA", curA, 32'h0);
      checkEq("opB", curB, 32'h11112222);
      checkEq("opD", curD, 32'h0);
   endtask

   task automatic interruptInjection(input bit enable);
      insnWord_t pc;
      logic [5:0] prevOpc;
      int injCount;
      loadProgram();
      // Slots after these words must not take the interrupt
      uMem.mem[1] = {IMM, 10'd0, 16'h0001};
      uMem.mem[2] = {RTD, 5'd15, 5'd0, 16'h0008};
      uMem.mem[3] = {BRI, 10'd0, 16'h0040};
      uMem.mem[4] = {BCC, 5'd1, 5'd2, 16'h0000};
      uMem.mem[5] = {BR, 5'd0, 5'd0, 5'd3, 11'd0};
      @(posedge gclk);
      msrIe <= enable;
      applyReset();
      nextDecoded();
      checkFields(uMem.mem[0]);
      @(posedge gclk);
      irq <= 1'b1;
      repeat (2) @(posedge gclk);
      irq <= 1'b0;
      pc = 32'd4;
      prevOpc = curWord[31:26];
      injCount = 0;
      for (int s = 1; s < 14; s++) begin
         nextDecoded();
         if (curWord == braliWord) begin
            injCount++;
            if (prevOpc inside {6'o54, 6'o55, 6'o46, 6'o56, 6'o47, 6'o57}) begin
               errors++;
               $display("Interrupt injected right after IMM, RTD or a branch");
            end
         end else begin
            checkFields(uMem.mem[pc[9:2]]);
         end
         // Replaced word is consumed as well
         pc = pc + 32'd4;
         prevOpc = curWord[31:26];
      end
      checkEq("injections", 32'(injCount), enable ? 32'd1 : 32'd0);
      @(posedge gclk);
      msrIe <= 1'b0;
   endtask

   task automatic stallThenRedirect();
      logic [191:0] snap;
      loadProgram();
      applyReset();
      nextDecoded();
      nextDecoded();
      @(posedge gclk);
      stall <= 1'b1;
      @(negedge gclk);
      snap = {rOpc, rRd, rRa, rImm, sImm, opA, opB, opD, 31'd0, decValid};
      repeat (6) begin
         @(negedge gclk);
         checkEq("heldOpc", 32'(rOpc), 32'(snap[191:186]));
         checkEq("heldFields", {rOpc, rRd, rRa, rImm}, snap[191:160]);
         checkEq("heldRb", 32'(rRb), 32'(snap[175:171]));
         checkEq("heldSImm", sImm, snap[159:128]);
         checkEq("heldOpA", opA, snap[127:96]);
         checkEq("heldOpB", opB, snap[95:64]);
         checkEq("heldOpD", opD, snap[63:32]);
         checkEq("heldValid", 32'(decValid), 32'(snap[0]));
      end
      @(posedge gclk);
      stall <= 1'b0;
      branchTaken <= 1'b1;
      branchTarget <= 32'h80;
      @(posedge gclk);
      branchTaken <= 1'b0;
      decQ.delete();
      // Dropped word leaves nothing valid behind
      @(negedge gclk);
      checkEq("decValid", 32'(decValid), 32'd0);
      for (int k = 0; k < 3; k++) begin
         nextDecoded();
         checkFields(uMem.mem[8'h20 + k[7:0]]);
      end
   endtask

   initial begin
      grst = 1'b1;
      msrIe = 1'b0;
      irq = 1'b0;
      stall = 1'b0;
      branchTaken = 1'b0;
      branchTarget = '0;
      wbEn = 1'b0;
      wbAddr = '0;
      wbData = '0;
      sequentialDecode();
      immediateForms();
      operandReads();
      interruptInjection(1'b1);
      interruptInjection(1'b0);
      stallThenRedirect();
      finishRun();
   end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
aembPkg.sv
insnFetch.sv
insnBuffer.sv
regFile.sv
aembFrontEnd.sv
tbInsnMem.sv
tbAembFrontEnd.sv

//--- Makefile
# Verilator build and run of the front end testbench

SRCS := $(filter-out +%,$(shell cat build.f)) aemb_config.svh

.PHONY: all run clean

all: obj_dir/VtbAembFrontEnd

# Simulator binary, rebuilt only when a source changes
obj_dir/V%: $(SRCS) build.f
	verilator --binary --timing --assert -j 0 --top-module $* -f build.f

# Pass only if the simulation prints the pass line
run: obj_dir/VtbAembFrontEnd
	@out="$$(./obj_dir/VtbAembFrontEnd)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir
